// ==== Bender.yml ====
package:
  name: stack

sources:
  - design/stack_pkg.sv
  - design/stack_cmd_reg.sv
  - design/stack_pointer.sv
  - design/stack_ring_mem.sv
  - design/stack_read_port.sv
  - design/stack.sv
  - target: test
    files:
      - test/stack_tb.sv

// ==== design/stack.sv ====
`default_nettype none

module stack (
   input  wire                   clk,
   input  wire                   arst_n,
   input  stack_pkg::stack_cmd_e   cmd,
   input  stack_pkg::stack_index_t index,
   input  stack_pkg::stack_data_t  data_in,
   output stack_pkg::stack_rsp_t   rsp
);

   stack_pkg::stack_req_t  req;
   stack_pkg::stack_ptr_t  top_ptr;
   stack_pkg::stack_ptr_t  rd_addr;
   stack_pkg::stack_data_t rd_data;

   // command sampled here, executed one edge later
   stack_cmd_reg u_cmd_reg (
      .clk     (clk),
      .arst_n  (arst_n),
      .cmd     (cmd),
      .index   (index),
      .data_in (data_in),
      .req     (req)
   );

   stack_pointer u_pointer (
      .clk     (clk),
      .arst_n  (arst_n),
      .req     (req),
      .top_ptr (top_ptr)
   );

   stack_ring_mem u_ring_mem (
      .clk     (clk),
      .arst_n  (arst_n),
      .req     (req),
      .top_ptr (top_ptr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // pop and get read against the pointer before it moves
   stack_read_port u_read_port (
      .clk     (clk),
      .arst_n  (arst_n),
      .req     (req),
      .top_ptr (top_ptr),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .rsp     (rsp)
   );

endmodule

`default_nettype wire

// ==== design/stack_cmd_reg.sv ====
`default_nettype none

module stack_cmd_reg (
   input  wire                   clk,
   input  wire                   arst_n,
   input  stack_pkg::stack_cmd_e   cmd,
   input  stack_pkg::stack_index_t index,
   input  stack_pkg::stack_data_t  data_in,
   output stack_pkg::stack_req_t   req
);

   stack_pkg::stack_cmd_e   cmd_q;
   stack_pkg::stack_index_t index_q;
   stack_pkg::stack_data_t  data_q;

   // command decides what the rest of the stack does next cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cmd_q <= stack_pkg::CMD_NOP;
      end else begin
         cmd_q <= cmd;
      end
   end

   // operands travel with the command
   always_ff @(posedge clk) begin
      index_q <= index;
      data_q  <= data_in;
   end

   always_comb begin
      req.cmd   = cmd_q;
      req.index = index_q;
      req.data  = data_q;
   end

endmodule

`default_nettype wire

// ==== design/stack_pkg.sv ====
`default_nettype none

package stack_pkg;

   // word and ring geometry
   localparam int DATA_W  = 4;
   localparam int DEPTH   = 5;
   localparam int INDEX_W = 3;
   localparam int PTR_W   = 3;

   typedef logic [DATA_W-1:0]  stack_data_t;
   typedef logic [INDEX_W-1:0] stack_index_t;

   // cell address kept below DEPTH
   typedef logic [PTR_W-1:0]   stack_ptr_t;

   // two-bit command codes with nop at zero
   typedef enum logic [1:0] {
      CMD_NOP  = 2'd0,
      CMD_PUSH = 2'd1,
      CMD_POP  = 2'd2,
      CMD_GET  = 2'd3
   } stack_cmd_e;

   // registered command with its operands
   typedef struct packed {
      stack_cmd_e   cmd;
      stack_index_t index;
      stack_data_t  data;
   } stack_req_t;

   // one-cycle result pulse whose data holds between pulses
   typedef struct packed {
      logic        valid;
      stack_data_t data;
   } stack_rsp_t;

endpackage

`default_nettype wire

// ==== design/stack_pointer.sv ====
`default_nettype none

module stack_pointer (
   input  wire                  clk,
   input  wire                  arst_n,
   input  stack_pkg::stack_req_t  req,
   output stack_pkg::stack_ptr_t  top_ptr
);

   localparam stack_pkg::stack_ptr_t LAST_CELL = stack_pkg::stack_ptr_t'(stack_pkg::DEPTH - 1);

   stack_pkg::stack_ptr_t ptr_next;

   // top_ptr is the cell the next push writes
   always_comb begin
      ptr_next = top_ptr;
      case (req.cmd)
         stack_pkg::CMD_PUSH: begin
            // wrap 4 -> 0
            if (top_ptr == LAST_CELL) begin
               ptr_next = '0;
            end else begin
               ptr_next = top_ptr + 1'b1;
            end
         end
         stack_pkg::CMD_POP: begin
            // wrap 0 -> 4
            if (top_ptr == '0) begin
               ptr_next = LAST_CELL;
            end else begin
               ptr_next = top_ptr - 1'b1;
            end
         end
         default: begin
            ptr_next = top_ptr;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         top_ptr <= '0;
      end else begin
         top_ptr <= ptr_next;
      end
   end

   a_ptr_in_range : assert property (
      @(posedge clk) disable iff (!arst_n)
      top_ptr < stack_pkg::DEPTH
   );

endmodule

`default_nettype wire

// ==== design/stack_read_port.sv ====
`default_nettype none

module stack_read_port (
   input  wire                   clk,
   input  wire                   arst_n,
   input  stack_pkg::stack_req_t   req,
   input  stack_pkg::stack_ptr_t   top_ptr,
   output stack_pkg::stack_ptr_t   rd_addr,
   input  stack_pkg::stack_data_t  rd_data,
   output stack_pkg::stack_rsp_t   rsp
);

   // one bit wider than a pointer, holds top_ptr + DEPTH - 1 - offset
   typedef logic [stack_pkg::PTR_W:0] sum_t;

   stack_pkg::stack_ptr_t offset;
   sum_t                  sum;
   logic                  rd_en;

   assign rd_en = (req.cmd == stack_pkg::CMD_POP) || (req.cmd == stack_pkg::CMD_GET);

   // depth below top, index 5..7 aliases 0..2
   always_comb begin
      offset = '0;
      if (req.cmd == stack_pkg::CMD_GET) begin
         if (req.index >= stack_pkg::DEPTH) begin
            offset = stack_pkg::stack_ptr_t'(req.index - stack_pkg::DEPTH);
         end else begin
            offset = stack_pkg::stack_ptr_t'(req.index);
         end
      end
   end

   // top word sits one cell below top_ptr, all modulo DEPTH
   always_comb begin
      sum = sum_t'(top_ptr) + sum_t'(stack_pkg::DEPTH - 1) - sum_t'(offset);
      if (sum >= sum_t'(stack_pkg::DEPTH)) begin
         rd_addr = stack_pkg::stack_ptr_t'(sum - sum_t'(stack_pkg::DEPTH));
      end else begin
         rd_addr = stack_pkg::stack_ptr_t'(sum);
      end
   end

   // valid pulses for one cycle, data is held until the next read
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp.valid <= 1'b0;
         rsp.data  <= '0;
      end else begin
         rsp.valid <= rd_en;
         if (rd_en) begin
            rsp.data <= rd_data;
         end
      end
   end

   // back-to-back pulses only for back-to-back reads
   a_valid_pairs : assert property (
      @(posedge clk) disable iff (!arst_n)
      (rsp.valid && $past(rsp.valid)) |->
         ($past(req.cmd) inside {stack_pkg::CMD_POP, stack_pkg::CMD_GET}) &&
         ($past(req.cmd, 2) inside {stack_pkg::CMD_POP, stack_pkg::CMD_GET})
   );

endmodule

`default_nettype wire

// ==== design/stack_ring_mem.sv ====
`default_nettype none

module stack_ring_mem (
   input  wire                   clk,
   input  wire                   arst_n,
   input  stack_pkg::stack_req_t   req,
   input  stack_pkg::stack_ptr_t   top_ptr,
   input  stack_pkg::stack_ptr_t   rd_addr,
   output stack_pkg::stack_data_t  rd_data
);

   stack_pkg::stack_data_t cells [stack_pkg::DEPTH];

   logic wr_en;

   // a push lands on the cell above the current top
   assign wr_en = (req.cmd == stack_pkg::CMD_PUSH);

   // cells start cleared, so an early pop or get returns zero
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < stack_pkg::DEPTH; i++) begin
            cells[i] <= '0;
         end
      end else if (wr_en) begin
         cells[top_ptr] <= req.data;
      end
   end

   // combinational read, registered in the read port
   always_comb begin
      rd_data = '0;
      for (int i = 0; i < stack_pkg::DEPTH; i++) begin
         if (rd_addr == stack_pkg::stack_ptr_t'(i)) begin
            rd_data = cells[i];
         end
      end
   end

   // the read port must only address real cells
   a_rd_addr_in_range : assert property (
      @(posedge clk) disable iff (!arst_n)
      (req.cmd inside {stack_pkg::CMD_POP, stack_pkg::CMD_GET}) |-> rd_addr < stack_pkg::DEPTH
   );

endmodule

`default_nettype wire

// ==== stack.f ====
design/stack_pkg.sv
design/stack_cmd_reg.sv
design/stack_pointer.sv
design/stack_ring_mem.sv
design/stack_read_port.sv
design/stack.sv
test/stack_tb.sv

// ==== test/stack_tb.sv ====
`default_nettype none

module stack_tb;

   localparam int DRAIN_CYCLES = 3;
   // commands per test including drain cycles
   localparam int CMD_TOTAL = 14 + 11 + 17 + 15 + 28;
   localparam int TIMEOUT_CYCLES = 2 * CMD_TOTAL + 50;

   logic                    clk;
   logic                    arst_n;
   stack_pkg::stack_cmd_e   cmd;
   stack_pkg::stack_index_t index;
   stack_pkg::stack_data_t  data_in;
   stack_pkg::stack_rsp_t   rsp;

   // reference ring model with its own pointer
   stack_pkg::stack_data_t model_ring [stack_pkg::DEPTH];
   int                     model_ptr;

   // expected responses in flight with [1] due at the coming negedge
   stack_pkg::stack_rsp_t  exp_pipe [2];
   stack_pkg::stack_data_t held_data;

   int err_cnt;
   int check_cnt;
   int tests_run;
   int tests_failed;
   int cycle_cnt;

   stack UUT (
      .clk     (clk),
      .arst_n  (arst_n),
      .cmd     (cmd),
      .index   (index),
      .data_in (data_in),
      .rsp     (rsp)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic check_data(input stack_pkg::stack_data_t exp, input stack_pkg::stack_data_t act);
      check_cnt = check_cnt + 1;
      if (act !== exp) begin
         err_cnt = err_cnt + 1;
         $display("[FAIL] rsp.data expected 0x%h, got 0x%h", exp, act);
      end
   endtask

   task automatic check_valid(input logic exp, input logic act);
      check_cnt = check_cnt + 1;
      if (act !== exp) begin
         err_cnt = err_cnt + 1;
         if (exp) begin
            $display("response missing: no valid pulse two cycles after a pop or get");
         end else begin
            $display("unexpected response: valid pulse after a push or nop");
         end
      end
   endtask

   // drive one command, advance the model, check the response due now
   task automatic issue(input stack_pkg::stack_cmd_e c, input stack_pkg::stack_index_t idx,
                        input stack_pkg::stack_data_t d);
      stack_pkg::stack_rsp_t exp;
      int                    depth;
      exp.valid = 1'b0;
      exp.data  = '0;
      @(posedge clk);
      cmd     <= c;
      index   <= idx;
      data_in <= d;
      case (c)
         stack_pkg::CMD_PUSH: begin
            model_ring[model_ptr] = d;
            model_ptr = (model_ptr + 1) % stack_pkg::DEPTH;
         end
         stack_pkg::CMD_POP: begin
            model_ptr = (model_ptr + stack_pkg::DEPTH - 1) % stack_pkg::DEPTH;
            exp.valid = 1'b1;
            exp.data  = model_ring[model_ptr];
         end
         stack_pkg::CMD_GET: begin
            depth = int'(idx) % stack_pkg::DEPTH;
            exp.valid = 1'b1;
            exp.data  = model_ring[(model_ptr + stack_pkg::DEPTH - 1 - depth) % stack_pkg::DEPTH];
         end
         default: begin
         end
      endcase
      @(negedge clk);
      // data holds its last value between pulses
      if (exp_pipe[1].valid) begin
         held_data = exp_pipe[1].data;
      end
      check_valid(exp_pipe[1].valid, rsp.valid);
      check_data(held_data, rsp.data);
      exp_pipe[1] = exp_pipe[0];
      exp_pipe[0] = exp;
   endtask

   task automatic idle(input int n);
      repeat (n) issue(stack_pkg::CMD_NOP, '0, '0);
   endtask

   function automatic stack_pkg::stack_data_t rand_word();
      return stack_pkg::stack_data_t'($urandom_range(0, 15));
   endfunction

   task automatic report_test(input string name, input int err_start);
      tests_run = tests_run + 1;
      if (err_cnt == err_start) begin
         $display("test %s: PASS", name);
      end else begin
         tests_failed = tests_failed + 1;
         $display("test %s: FAIL with %0d errors", name, err_cnt - err_start);
      end
   endtask

   task automatic test_reset_state();
      int err_start;
      err_start = err_cnt;
      idle(10);
      issue(stack_pkg::CMD_GET, 3'd0, '0);
      idle(DRAIN_CYCLES);
      report_test("reset state", err_start);
   endtask

   task automatic test_push_pop();
      int err_start;
      err_start = err_cnt;
      repeat (4) issue(stack_pkg::CMD_PUSH, '0, rand_word());
      repeat (4) issue(stack_pkg::CMD_POP, '0, '0);
      idle(DRAIN_CYCLES);
      report_test("push then pop", err_start);
   endtask

   task automatic test_get_index();
      int err_start;
      err_start = err_cnt;
      repeat (5) issue(stack_pkg::CMD_PUSH, '0, rand_word());
      for (int i = 0; i < 8; i++) begin
         issue(stack_pkg::CMD_GET, stack_pkg::stack_index_t'(i), '0);
      end
      // top word must be untouched by the gets
      issue(stack_pkg::CMD_POP, '0, '0);
      idle(DRAIN_CYCLES);
      report_test("get by index", err_start);
   endtask

   task automatic test_ring_wrap();
      int err_start;
      err_start = err_cnt;
      repeat (7) issue(stack_pkg::CMD_PUSH, '0, rand_word());
      repeat (5) issue(stack_pkg::CMD_POP, '0, '0);
      idle(DRAIN_CYCLES);
      report_test("ring wrap", err_start);
   endtask

   task automatic test_mixed_stream();
      int err_start;
      err_start = err_cnt;
      for (int i = 0; i < 25; i++) begin
         case (i % 5)
            0, 1: issue(stack_pkg::CMD_PUSH, '0, rand_word());
            2: issue(stack_pkg::CMD_GET, stack_pkg::stack_index_t'($urandom_range(0, 7)), '0);
            3: issue(stack_pkg::CMD_POP, '0, '0);
            default: issue(stack_pkg::CMD_NOP, '0, '0);
         endcase
      end
      idle(DRAIN_CYCLES);
      report_test("back-to-back mix", err_start);
   endtask

   initial begin
      clk          = 1'b0;
      arst_n       = 1'b0;
      cmd          = stack_pkg::CMD_NOP;
      index        = '0;
      data_in      = '0;
      err_cnt      = 0;
      check_cnt    = 0;
      tests_run    = 0;
      tests_failed = 0;
      cycle_cnt    = 0;
      model_ptr    = 0;
      held_data    = '0;
      void'($urandom(32'hbb78a027));
      for (int i = 0; i < stack_pkg::DEPTH; i++) begin
         model_ring[i] = '0;
      end
      exp_pipe[0] = '0;
      exp_pipe[1] = '0;

      repeat (5) @(posedge clk);
      arst_n <= 1'b1;

      test_reset_state();
      test_push_pop();
      test_get_index();
      test_ring_wrap();
      test_mixed_stream();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
